// File: design/cnn_pkg.sv
package cnn_pkg;

    // geometry
    localparam int img_dim   = 8;
    localparam int conv_dim  = 6;
    localparam int pool_dim  = 3;
    localparam int k_side    = 3;
    localparam int pool_side = 2;
    localparam int k_taps    = k_side * k_side;
    localparam int pool_taps = pool_side * pool_side;

    // kernel, then fc weights, then image
    localparam int load_words = 2 * k_taps + img_dim * img_dim;

    // widths
    localparam int pix_w = 8;
    localparam int wgt_w = 8;
    localparam int acc_w = 20;
    localparam int pix_max = (1 << pix_w) - 1;

    // weight store map
    localparam int fc_wt_base = k_taps;
    localparam int wgt_words  = 2 * k_taps;
    localparam int wgt_aw     = 5;

    // feature store map: image, conv1, pool1 back to back
    localparam int conv1_base = img_dim * img_dim;
    localparam int pool1_base = conv1_base + conv_dim * conv_dim;
    localparam int fmap_words = pool1_base + pool_dim * pool_dim;
    localparam int fmap_aw    = 7;

    typedef enum logic [2:0] {
        step_load,
        step_conv1,
        step_pool1,
        step_fc,
        step_out
    } step_e;

    typedef enum logic [1:0] {
        mode_conv,
        mode_max,
        mode_fc
    } mac_mode_e;

    typedef struct packed {
        logic [pix_w-1:0]        pixel;
        logic signed [wgt_w-1:0] weight;
        logic                    last;   // final tap of the window
    } elem_t;

    typedef struct packed {
        logic signed [acc_w-1:0] value;
        logic                    last_of_layer;
    } result_t;

endpackage

// File: design/cnn_layer_ctrl.sv
module cnn_layer_ctrl (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               step_done,
    output cnn_pkg::step_e     step,
    output cnn_pkg::mac_mode_e mac_mode,
    output logic               layer_start,
    output logic               busy
);

    cnn_pkg::step_e step_q;
    cnn_pkg::step_e step_nxt;

    // fixed run order, out wraps back to load
    always_comb begin
        case (step_q)
            cnn_pkg::step_load:  step_nxt = cnn_pkg::step_conv1;
            cnn_pkg::step_conv1: step_nxt = cnn_pkg::step_pool1;
            cnn_pkg::step_pool1: step_nxt = cnn_pkg::step_fc;
            cnn_pkg::step_fc:    step_nxt = cnn_pkg::step_out;
            default:             step_nxt = cnn_pkg::step_load;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            step_q      <= cnn_pkg::step_load;
            layer_start <= 1'b0;
        end else begin
            layer_start <= step_done;   // first cycle of the new step
            if (step_done) begin
                step_q <= step_nxt;
            end
        end
    end

    // layer select into mac mode
    always_comb begin
        case (step_q)
            cnn_pkg::step_pool1: mac_mode = cnn_pkg::mode_max;
            cnn_pkg::step_fc:    mac_mode = cnn_pkg::mode_fc;
            default:             mac_mode = cnn_pkg::mode_conv;
        endcase
    end

    assign step = step_q;
    assign busy = (step_q != cnn_pkg::step_load);

endmodule

// File: design/window_gen.sv
module window_gen (
    input  logic                              clk,
    input  logic                              arst_n,
    input  cnn_pkg::step_e                    step,
    input  logic                              layer_start,
    output logic [cnn_pkg::fmap_aw-1:0]       rd_addr,
    output logic [cnn_pkg::wgt_aw-1:0]        wt_addr,
    input  logic [cnn_pkg::pix_w-1:0]         rd_data,
    input  logic signed [cnn_pkg::wgt_w-1:0]  wt_data,
    output logic                              elem_valid,
    input  logic                              elem_ready,
    output cnn_pkg::elem_t                    elem
);

    logic       active;
    logic [2:0] win_r, win_c;
    logic [1:0] tap_r, tap_c;

    // per layer walk
    logic [2:0] n_win;
    logic [1:0] n_tap;
    logic [3:0] n_taps;
    logic [1:0] stride;
    logic [3:0] src_w;
    logic [cnn_pkg::fmap_aw-1:0] src_base;
    logic [cnn_pkg::wgt_aw-1:0]  wt_base;
    logic       use_wt;

    logic [3:0] row, col, tap_idx;
    logic       last_tap, fire;

    always_comb begin
        n_win = 3'd1; n_tap = 2'd1; n_taps = 4'd1; stride = 2'd0;
        src_w = 4'd1; src_base = '0; wt_base = '0; use_wt = 1'b0;
        case (step)
            cnn_pkg::step_conv1: begin
                n_win = 3'(cnn_pkg::conv_dim); n_tap = 2'(cnn_pkg::k_side);
                n_taps = 4'(cnn_pkg::k_taps); stride = 2'd1;
                src_w = 4'(cnn_pkg::img_dim); use_wt = 1'b1;
            end
            cnn_pkg::step_pool1: begin
                n_win = 3'(cnn_pkg::pool_dim); n_tap = 2'(cnn_pkg::pool_side);
                n_taps = 4'(cnn_pkg::pool_taps); stride = 2'd2;
                src_w = 4'(cnn_pkg::conv_dim); src_base = 7'(cnn_pkg::conv1_base);
            end
            cnn_pkg::step_fc: begin
                n_tap = 2'(cnn_pkg::k_side); n_taps = 4'(cnn_pkg::k_taps);
                src_w = 4'(cnn_pkg::pool_dim); src_base = 7'(cnn_pkg::pool1_base);
                wt_base = 5'(cnn_pkg::fc_wt_base); use_wt = 1'b1;
            end
            default: ;
        endcase
    end

    assign row      = win_r * stride + tap_r;
    assign col      = win_c * stride + tap_c;
    assign tap_idx  = tap_r * n_tap + tap_c;
    assign rd_addr  = src_base + row * src_w + col;
    assign wt_addr  = use_wt ? wt_base + 5'(tap_idx) : '0;
    assign last_tap = (tap_idx == n_taps - 1);
    assign fire     = active && elem_ready;

    assign elem_valid  = active;
    assign elem.pixel  = rd_data;   // same cycle read
    assign elem.weight = use_wt ? wt_data : '0;
    assign elem.last   = last_tap;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            active <= 1'b0;
            {win_r, win_c, tap_r, tap_c} <= '0;
        end else if (layer_start) begin
            {win_r, win_c, tap_r, tap_c} <= '0;
            active <= step inside {cnn_pkg::step_conv1, cnn_pkg::step_pool1, cnn_pkg::step_fc};
        end else if (fire) begin
            if (tap_c != n_tap - 1) begin
                tap_c <= tap_c + 1'b1;
            end else begin
                tap_c <= '0;
                if (tap_r != n_tap - 1) begin
                    tap_r <= tap_r + 1'b1;
                end else begin
                    tap_r <= '0;
                    if (win_c != n_win - 1) begin
                        win_c <= win_c + 1'b1;
                    end else begin
                        win_c <= '0;
                        win_r <= win_r + 1'b1;
                        if (win_r == n_win - 1) begin
                            active <= 1'b0;   // final window done
                        end
                    end
                end
            end
        end
    end

endmodule

// File: design/pipe_slice.sv
module pipe_slice #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    // accept when empty or draining this cycle
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_data <= in_data;
        end
    end

endmodule

// File: design/mac_pool_unit.sv
module mac_pool_unit (
    input  logic               clk,
    input  logic               arst_n,
    input  cnn_pkg::mac_mode_e mac_mode,
    input  logic               elem_valid,
    output logic               elem_ready,
    input  cnn_pkg::elem_t     elem,
    output logic               res_valid,
    input  logic               res_ready,
    output cnn_pkg::result_t   res
);

    logic signed [cnn_pkg::acc_w-1:0] acc_q, acc_nxt, prod, pix_ext, final_val;
    logic [5:0] win_cnt, n_win_layer;
    logic       last_win, fire;
    logic       res_valid_q;
    cnn_pkg::result_t res_q;

    assign pix_ext = cnn_pkg::acc_w'(elem.pixel);
    assign prod    = $signed({1'b0, elem.pixel}) * elem.weight;   // unsigned pixel, signed weight

    always_comb begin
        if (mac_mode == cnn_pkg::mode_max) begin
            acc_nxt = (pix_ext > acc_q) ? pix_ext : acc_q;
        end else begin
            acc_nxt = acc_q + prod;
        end
    end

    // relu and clamp for conv only
    always_comb begin
        final_val = acc_nxt;
        if (mac_mode == cnn_pkg::mode_conv) begin
            if (acc_nxt < 0) begin
                final_val = '0;
            end else if (acc_nxt > cnn_pkg::pix_max) begin
                final_val = cnn_pkg::acc_w'(cnn_pkg::pix_max);
            end
        end
    end

    always_comb begin
        case (mac_mode)
            cnn_pkg::mode_max: n_win_layer = 6'(cnn_pkg::pool_dim * cnn_pkg::pool_dim);
            cnn_pkg::mode_fc:  n_win_layer = 6'd1;
            default:           n_win_layer = 6'(cnn_pkg::conv_dim * cnn_pkg::conv_dim);
        endcase
    end

    assign last_win   = (win_cnt == n_win_layer - 1);
    assign elem_ready = !res_valid_q;   // stall while a result waits
    assign fire       = elem_valid && elem_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            acc_q       <= '0;
            res_valid_q <= 1'b0;
            win_cnt     <= '0;
        end else begin
            if (res_valid_q && res_ready) begin
                res_valid_q <= 1'b0;
            end
            if (fire) begin
                if (elem.last) begin
                    acc_q       <= '0;
                    res_valid_q <= 1'b1;
                    win_cnt     <= last_win ? '0 : win_cnt + 1'b1;
                end else begin
                    acc_q <= acc_nxt;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fire && elem.last) begin
            res_q.value         <= final_val;
            res_q.last_of_layer <= last_win;
        end
    end

    assign res_valid = res_valid_q;
    assign res       = res_q;

endmodule

// File: design/feature_store.sv
module feature_store (
    input  logic                              clk,
    input  logic                              arst_n,
    input  cnn_pkg::step_e                    step,
    input  logic                              layer_start,
    input  logic [cnn_pkg::pix_w-1:0]         load_data,
    input  logic                              load_valid,
    output logic                              load_ready,
    input  logic [cnn_pkg::fmap_aw-1:0]       rd_addr,
    input  logic [cnn_pkg::wgt_aw-1:0]        wt_addr,
    output logic [cnn_pkg::pix_w-1:0]         rd_data,
    output logic signed [cnn_pkg::wgt_w-1:0]  wt_data,
    input  logic                              res_valid,
    output logic                              res_ready,
    input  cnn_pkg::result_t                  res,
    output logic signed [cnn_pkg::acc_w-1:0]  result_data,
    output logic                              result_valid,
    input  logic                              result_ready,
    output logic                              step_done
);

    logic signed [cnn_pkg::wgt_w-1:0] wgt_mem [cnn_pkg::wgt_words];
    logic [cnn_pkg::pix_w-1:0]        fmap [cnn_pkg::fmap_words];   // image, conv1, pool1

    logic [6:0] load_cnt;
    logic [6:0] img_addr;
    logic [cnn_pkg::fmap_aw-1:0] wr_cnt, wr_base;
    logic signed [cnn_pkg::acc_w-1:0] result_q;
    logic result_valid_q;
    logic load_fire, res_fire, out_fire, load_last, to_result;

    assign load_ready = (step == cnn_pkg::step_load);
    assign res_ready  = !result_valid_q;
    assign load_fire  = load_valid && load_ready;
    assign res_fire   = res_valid && res_ready;
    assign out_fire   = result_valid_q && result_ready;
    assign load_last  = (load_cnt == 7'(cnn_pkg::load_words - 1));
    assign to_result  = (step == cnn_pkg::step_fc);
    assign img_addr   = load_cnt - 7'(cnn_pkg::wgt_words);
    assign wr_base    = (step == cnn_pkg::step_pool1) ? 7'(cnn_pkg::pool1_base)
                                                      : 7'(cnn_pkg::conv1_base);

    assign step_done = (load_fire && load_last) || (res_fire && res.last_of_layer) || out_fire;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            load_cnt       <= '0;
            wr_cnt         <= '0;
            result_valid_q <= 1'b0;
        end else begin
            // a word may already arrive in the entry cycle of step_load
            if (load_fire) begin
                load_cnt <= load_last ? '0 : load_cnt + 1'b1;
            end else if (layer_start) begin
                load_cnt <= '0;
            end
            if (layer_start) begin
                wr_cnt <= '0;
            end else if (res_fire && !to_result) begin
                wr_cnt <= wr_cnt + 1'b1;
            end
            if (res_fire && to_result) begin
                result_valid_q <= 1'b1;
            end else if (out_fire) begin
                result_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_fire) begin
            if (load_cnt < 7'(cnn_pkg::wgt_words)) begin
                wgt_mem[load_cnt[cnn_pkg::wgt_aw-1:0]] <= load_data;
            end else begin
                fmap[img_addr] <= load_data;
            end
        end
        if (res_fire && !to_result) begin
            fmap[wr_base + wr_cnt] <= res.value[cnn_pkg::pix_w-1:0];   // already clamped
        end
        if (res_fire && to_result) begin
            result_q <= res.value;
        end
    end

    assign rd_data      = fmap[rd_addr];
    assign wt_data      = wgt_mem[wt_addr];
    assign result_data  = result_q;
    assign result_valid = result_valid_q;

endmodule

// File: design/cnn_top.sv
module cnn_top (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic [cnn_pkg::pix_w-1:0]         load_data,
    input  logic                              load_valid,
    output logic                              load_ready,
    output logic signed [cnn_pkg::acc_w-1:0]  result_data,
    output logic                              result_valid,
    input  logic                              result_ready,
    output logic                              busy
);

    cnn_pkg::step_e     step;
    cnn_pkg::mac_mode_e mac_mode;
    logic               layer_start;
    logic               step_done;

    logic [cnn_pkg::fmap_aw-1:0]      rd_addr;
    logic [cnn_pkg::wgt_aw-1:0]       wt_addr;
    logic [cnn_pkg::pix_w-1:0]        rd_data;
    logic signed [cnn_pkg::wgt_w-1:0] wt_data;

    // window gen -> slice -> mac
    logic             win_valid, win_ready;
    cnn_pkg::elem_t   win_elem;
    logic             mac_valid, mac_ready;
    cnn_pkg::elem_t   mac_elem;

    // mac -> slice -> store
    logic             res_valid, res_ready;
    cnn_pkg::result_t res;
    logic             st_valid, st_ready;
    cnn_pkg::result_t st_res;

    cnn_layer_ctrl u_ctrl (
        .clk, .arst_n, .step_done, .step, .mac_mode, .layer_start, .busy
    );

    window_gen u_win (
        .clk, .arst_n, .step, .layer_start, .rd_addr, .wt_addr, .rd_data, .wt_data,
        .elem_valid(win_valid), .elem_ready(win_ready), .elem(win_elem)
    );

    pipe_slice #(.payload_t(cnn_pkg::elem_t)) u_slice_elem (
        .clk, .arst_n,
        .in_valid(win_valid),  .in_ready(win_ready),  .in_data(win_elem),
        .out_valid(mac_valid), .out_ready(mac_ready), .out_data(mac_elem)
    );

    mac_pool_unit u_mac (
        .clk, .arst_n, .mac_mode,
        .elem_valid(mac_valid), .elem_ready(mac_ready), .elem(mac_elem),
        .res_valid, .res_ready, .res
    );

    pipe_slice #(.payload_t(cnn_pkg::result_t)) u_slice_res (
        .clk, .arst_n,
        .in_valid(res_valid), .in_ready(res_ready), .in_data(res),
        .out_valid(st_valid), .out_ready(st_ready), .out_data(st_res)
    );

    feature_store u_store (
        .clk, .arst_n, .step, .layer_start,
        .load_data, .load_valid, .load_ready,
        .rd_addr, .wt_addr, .rd_data, .wt_data,
        .res_valid(st_valid), .res_ready(st_ready), .res(st_res),
        .result_data, .result_valid, .result_ready, .step_done
    );

endmodule

// File: testbench/cnn_checker.sv
module cnn_checker (
    input logic                             clk,
    input logic                             arst_n,
    input logic                             result_valid,
    input logic                             result_ready,
    input logic signed [cnn_pkg::acc_w-1:0] result_data,
    input logic                             load_ready,
    input logic                             busy,
    input cnn_pkg::step_e                   step
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;   // failed assertions so far

    // an offered result stays put until taken
    a_result_hold: assert property (
        @(posedge clk) disable iff (!arst_n)
        result_valid && !result_ready |=> result_valid && $stable(result_data)
    ) else begin
        $error("result stream dropped or changed a result before it was accepted");
        fail_count++;
    end

    // no loading while a run or its result is pending
    a_load_idle: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(load_ready && (busy || result_valid))
    ) else begin
        $error("load_ready was high while the engine was busy or held a result");
        fail_count++;
    end

    // next step in order, or out back to load
    a_step_order: assert property (
        @(posedge clk) disable iff (!arst_n)
        step != $past(step) |->
            (3'(step) == 3'($past(step)) + 3'd1) ||
            ($past(step) == cnn_pkg::step_out && step == cnn_pkg::step_load)
    ) else begin
        $error("step left the fixed sequence");
        fail_count++;
    end

endmodule

bind cnn_top cnn_checker chk_i (
    .clk, .arst_n, .result_valid, .result_ready, .result_data, .load_ready, .busy, .step
);

// File: testbench/cnn_tb.sv
module cnn_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int n_tests         = 6;
    localparam int cycles_per_test = 2000;
    localparam int clk_period      = 20;

    logic                             clk = 1'b0;
    logic                             arst_n;
    logic [cnn_pkg::pix_w-1:0]        load_data;
    logic                             load_valid;
    logic                             load_ready;
    logic signed [cnn_pkg::acc_w-1:0] result_data;
    logic                             result_valid;
    logic                             result_ready;
    logic                             busy;

    int kern [9];
    int fcw [9];
    int img [64];
    logic [31:0] rng = 32'h3b2c;
    int errors;
    int checks;
    int tests_failed;

    cnn_top dut_i (
        .clk, .arst_n, .load_data, .load_valid, .load_ready,
        .result_data, .result_valid, .result_ready, .busy
    );

    always #(clk_period / 2) clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // conv1 + relu + clamp, 2x2 max pool, then 9-tap dot product
    function automatic int model_fc();
        int conv [36];
        int pool [9];
        int s;
        for (int r = 0; r < 6; r++) begin
            for (int c = 0; c < 6; c++) begin
                s = 0;
                for (int t = 0; t < 9; t++) begin
                    s += img[(r + t / 3) * 8 + c + t % 3] * kern[t];
                end
                conv[r * 6 + c] = (s < 0) ? 0 : ((s > 255) ? 255 : s);
            end
        end
        for (int p = 0; p < 9; p++) begin
            pool[p] = 0;
            for (int t = 0; t < 4; t++) begin
                s = conv[(2 * (p / 3) + t / 2) * 6 + 2 * (p % 3) + t % 2];
                pool[p] = (s > pool[p]) ? s : pool[p];
            end
        end
        s = 0;
        for (int k = 0; k < 9; k++) begin
            s += pool[k] * fcw[k];
        end
        return s;
    endfunction

    function automatic logic [7:0] word_at(input int n);
        if (n < 9) begin
            return 8'(kern[n]);
        end
        if (n < 18) begin
            return 8'(fcw[n - 9]);
        end
        return 8'(img[n - 18]);
    endfunction

    task automatic check_val(input string name, input int got, input int exp);
        checks++;
        assert (got == exp) else begin
            $display("FAIL %0t ns %s got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic load_all(input bit gaps);
        int waited;
        waited = 0;
        while (!load_ready && waited < cycles_per_test) begin
            @(posedge clk);
            #2;
            waited++;
        end
        for (int n = 0; n < cnn_pkg::load_words; n++) begin
            rng = xorshift32(rng);
            while (gaps && rng[1:0] == 2'd0) begin
                load_valid = 1'b0;
                @(posedge clk);
                #2;
                rng = xorshift32(rng);
            end
            load_valid = 1'b1;
            load_data  = word_at(n);
            checks++;
            assert (load_ready) else begin
                $display("load_ready was low while load word %0d was offered", n);
                errors++;
            end
            @(posedge clk);
            #2;
        end
        load_valid = 1'b0;
    endtask

    task automatic run_check(input bit gaps, input int hold, output int got);
        int exp;
        int waited;
        exp = model_fc();
        load_all(gaps);
        waited = 0;
        while (!result_valid && waited < cycles_per_test) begin
            @(posedge clk);
            #2;
            waited++;
        end
        checks++;
        assert (result_valid) else begin
            $display("no result within %0d cycles after loading", cycles_per_test);
            errors++;
        end
        repeat (hold) begin   // result_ready kept low
            @(posedge clk);
            #2;
            check_val("result_valid", result_valid, 1);
            check_val("result_data", result_data, exp);
            check_val("load_ready", load_ready, 0);
        end
        got = result_data;
        check_val("result_data", got, exp);
        result_ready = 1'b1;
        @(posedge clk);
        #2;
        result_ready = 1'b0;
        check_val("result_valid", result_valid, 0);
        check_val("load_ready", load_ready, 1);
    endtask

    task automatic fill_random();
        for (int i = 0; i < 9; i++) begin
            rng = xorshift32(rng);
            kern[i] = int'($signed(rng[3:0]));
            fcw[i]  = int'($signed(rng[15:8]));
        end
        for (int i = 0; i < 64; i++) begin
            rng = xorshift32(rng);
            img[i] = int'(rng[7:0]);
        end
    endtask

    task automatic test_reset();
        check_val("load_ready", load_ready, 1);
        check_val("result_valid", result_valid, 0);
        check_val("busy", busy, 0);
    endtask

    task automatic test_identity();
        int got;
        for (int i = 0; i < 9; i++) begin
            kern[i] = (i == 4) ? 1 : 0;
            fcw[i]  = 1;
        end
        for (int i = 0; i < 64; i++) begin
            img[i] = i;
        end
        run_check(1'b0, 0, got);
    endtask

    task automatic test_back_to_back();
        int got;
        repeat (3) begin
            fill_random();
            run_check(1'b0, 0, got);
        end
    endtask

    // alternating columns saturate high, flat rows go negative
    task automatic test_relu_sat();
        int got;
        for (int i = 0; i < 9; i++) begin
            kern[i] = (i == 3) ? -4 : ((i == 4) ? 3 : 0);
            fcw[i]  = i - 4;
        end
        for (int i = 0; i < 64; i++) begin
            img[i] = (i / 8 >= 1 && i / 8 <= 3) ? ((i % 2 == 0) ? 250 : 20) : 100;
        end
        run_check(1'b0, 0, got);
        check_val("result_data", got, -2295);
    endtask

    task automatic test_backpressure();
        int got;
        fill_random();
        run_check(1'b0, 50, got);
    endtask

    task automatic test_load_gaps();
        int got;
        fill_random();
        run_check(1'b1, 0, got);
    endtask

    task automatic finish_test(input string name, input int err_before);
        if (errors == err_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - err_before);
            tests_failed++;
        end
    endtask

    initial begin
        int e;
        arst_n       = 1'b0;
        load_valid   = 1'b0;
        load_data    = '0;
        result_ready = 1'b0;
        errors       = 0;
        checks       = 0;
        tests_failed = 0;
        repeat (10) @(posedge clk);
        #2;
        arst_n = 1'b1;
        e = errors;
        test_reset();
        finish_test("reset", e);
        e = errors;
        test_identity();
        finish_test("identity", e);
        e = errors;
        test_back_to_back();
        finish_test("back_to_back", e);
        e = errors;
        test_relu_sat();
        finish_test("relu_sat", e);
        e = errors;
        test_backpressure();
        finish_test("backpressure", e);
        e = errors;
        test_load_gaps();
        finish_test("load_gaps", e);
        errors += dut_i.chk_i.fail_count;
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 n_tests, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        #(n_tests * cycles_per_test * clk_period);
        $display("watchdog expired before the tests completed");
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// File: filelist.f
design/cnn_pkg.sv
design/cnn_layer_ctrl.sv
design/window_gen.sv
design/pipe_slice.sv
design/mac_pool_unit.sv
design/feature_store.sv
design/cnn_top.sv
testbench/cnn_checker.sv
testbench/cnn_tb.sv

// File: Bender.yml
package:
  name: cnn_engine

sources:
  - files:
      - design/cnn_pkg.sv
      - design/cnn_layer_ctrl.sv
      - design/window_gen.sv
      - design/pipe_slice.sv
      - design/mac_pool_unit.sv
      - design/feature_store.sv
      - design/cnn_top.sv
  - target: test
    files:
      - testbench/cnn_checker.sv
      - testbench/cnn_tb.sv
